/* build.f */
+incdir+verif
hw/cmd_pkg.sv
hw/cmd_decoder.sv
hw/setting_reg.sv
hw/flag_bank.sv
hw/channel_mask.sv
hw/onehot_select.sv
hw/pulse_gen.sv
hw/cmd_interpreter_top.sv
verif/tb_cmd_interpreter.sv

/* hw/channel_mask.sv */
`timescale 1ns/100ps

module channel_mask
(
    input  logic                            clk,
    input  logic                            reset_n,
    input  cmd_pkg::mask_op_t               op,
    input  logic [cmd_pkg::MASK_CHAN_W-1:0] chan,
    output cmd_pkg::chan_mask_t             mask
);
    import cmd_pkg::*;

    ////////////////////////////////////////
    // 64 channel mask
    ////////////////////////////////////////
    // A set bit masks the channel. The decoder has already mapped
    // channel n to bit position 64 - n
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            mask <= CHAN_MASK_DEFAULT;                          // No channel masked
        end
        else
        begin
            case (op)
                MASK_CLEAR_ALL:
                    mask <= '0;
                MASK_SET_ALL:
                    mask <= '1;
                MASK_SET_BIT:
                    mask[chan] <= 1'b1;
                MASK_CLEAR_BIT:
                    mask[chan] <= 1'b0;
                default:
                    mask <= mask;                               // MASK_NONE
            endcase
        end
    end

endmodule

/* hw/cmd_decoder.sv */
`timescale 1ns/100ps

module cmd_decoder
(
    input  logic                  clk,
    input  logic                  reset_n,
    input  logic                  cmd_valid,
    input  cmd_pkg::ctrl_word_t   cmd_word,
    output cmd_pkg::decoded_cmd_t dec
);
    import cmd_pkg::*;

    decoded_cmd_t           dec_d;
    logic                   flag_hit;
    flag_idx_t              flag_hit_idx;
    logic                   chan_ok;
    logic                   mode_ok;
    logic [MASK_CHAN_W-1:0] chan_pos;

    assign chan_ok  = (cmd_word[7:0] != 8'd0) && (cmd_word[7:0] <= 8'(NUM_CHANNELS));
    assign mode_ok  = (cmd_word[7:0] != 8'd0) && (cmd_word[7:0] <= 8'd4);
    assign chan_pos = '0 - cmd_word[MASK_CHAN_W-1:0];     // 64 - nn, channel 64 wraps to 0

    // Flag pairs differ from their set code only in bit 0
    always_comb
    begin
        flag_hit     = 1'b0;
        flag_hit_idx = '0;
        for (int i = 0; i < NUM_FLAGS; i++)
        begin
            if (cmd_word[15:1] == FLAG_CODE[i][15:1])
            begin
                flag_hit     = 1'b1;
                flag_hit_idx = flag_idx_t'(i);
            end
        end
    end

    ////////////////////////////////////////
    // Command table
    ////////////////////////////////////////
    always_comb
    begin
        dec_d = '0;
        if (cmd_valid)
        begin
            if (flag_hit)
            begin
                dec_d.flag_we  = 1'b1;
                dec_d.flag_idx = flag_hit_idx;
                dec_d.flag_val = cmd_word[0];                   // 1 sets, 0 clears
            end
            else if (cmd_word[15:12] == CMD_CALI_PREFIX)
            begin
                dec_d.cali_we = 1'b1;
                dec_d.arg     = cmd_word[11:0];
            end
            else if (cmd_word[15:8] == CMD_DELAY_PREFIX)
            begin
                dec_d.delay_we = 1'b1;
                dec_d.arg      = ARG_W'(cmd_word[7:0]);
            end
            else if (cmd_word[15:4] == CMD_FBCAP_PREFIX)
            begin
                dec_d.fbcap_we = 1'b1;
                dec_d.arg      = ARG_W'(cmd_word[3:0]);
            end
            else if (cmd_word[15:8] == CMD_MODE_PREFIX && mode_ok)
            begin
                dec_d.mode_we = 1'b1;
                dec_d.mode    = trig_mode_t'(4'b0001 << (cmd_word[1:0] - 2'd1));
            end
            else if (cmd_word == CMD_MASK_CLEAR)
                dec_d.mask_op = MASK_CLEAR_ALL;
            else if (cmd_word == CMD_MASK_ALL)
                dec_d.mask_op = MASK_SET_ALL;
            else if (cmd_word[15:8] == CMD_MASK_SET_PREFIX && chan_ok)
            begin
                dec_d.mask_op   = MASK_SET_BIT;
                dec_d.mask_chan = chan_pos;
            end
            else if (cmd_word[15:8] == CMD_MASK_CLR_PREFIX && chan_ok)
            begin
                dec_d.mask_op   = MASK_CLEAR_BIT;
                dec_d.mask_chan = chan_pos;
            end
            else if (cmd_word[15:8] == CMD_PROBE_PREFIX)
            begin
                dec_d.probe_we = 1'b1;
                dec_d.sel_idx  = cmd_word[7:0];                 // Selector does its own range check
            end
            else if (cmd_word[15:8] == CMD_RES_PREFIX)
            begin
                dec_d.res_we  = 1'b1;
                dec_d.sel_idx = cmd_word[7:0];
            end
            else if (cmd_word == CMD_START_CONFIG)
                dec_d.fire[FIRE_START_CONFIG] = 1'b1;
            else if (cmd_word == CMD_FORCE_TRIG)
                dec_d.fire[FIRE_FORCE_TRIG] = 1'b1;
            else if (cmd_word == CMD_RESET_ASIC)
                dec_d.fire[FIRE_RESET_ASIC] = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            dec <= '0;
        else
            dec <= dec_d;
    end

    // Only one downstream block may act on any cycle
    a_one_cmd: assert property (@(posedge clk) disable iff (!reset_n)
        $onehot0({dec.flag_we, dec.cali_we, dec.delay_we, dec.fbcap_we, dec.mode_we,
                  dec.mask_op != MASK_NONE, dec.probe_we, dec.res_we, dec.fire}))
        else $error("cmd_decoder: more than one command strobe active");

endmodule

/* hw/cmd_interpreter_top.sv */
`timescale 1ns/100ps

module cmd_interpreter_top
(
    input  logic                             clk,
    input  logic                             reset_n,
    input  logic                             cmd_valid,
    input  cmd_pkg::ctrl_word_t              cmd_word,
    output cmd_pkg::flags_t                  flags,
    output cmd_pkg::cali_dac_t               cali_dac,
    output cmd_pkg::trig_delay_t             trig_delay,
    output cmd_pkg::fb_cap_t                 fb_cap,
    output cmd_pkg::trig_mode_t              trig_mode,
    output cmd_pkg::chan_mask_t              chan_mask,
    output logic [cmd_pkg::NUM_PROBES-1:0]   probe_sel,
    output logic [cmd_pkg::NUM_CHANNELS-1:0] res_sel,
    output logic                             start_config,
    output logic                             force_trig,
    output logic                             reset_asic_b
);
    import cmd_pkg::*;

    decoded_cmd_t dec;
    logic         reset_asic;

    ////////////////////////////////////////
    // Decode stage
    ////////////////////////////////////////
    cmd_decoder cmd_decoder_inst (.clk, .reset_n, .cmd_valid, .cmd_word, .dec);

    ////////////////////////////////////////
    // Settings
    ////////////////////////////////////////
    flag_bank flag_bank_inst (.clk, .reset_n, .we(dec.flag_we), .idx(dec.flag_idx),
                              .val(dec.flag_val), .flags);

    setting_reg #(.payload_t(cali_dac_t), .RESET_VAL(CALI_DAC_DEFAULT)) cali_dac_inst
        (.clk, .reset_n, .load(dec.cali_we), .data(dec.arg[CALI_DAC_W-1:0]), .value(cali_dac));

    setting_reg #(.payload_t(trig_delay_t), .RESET_VAL(TRIG_DELAY_DEFAULT)) trig_delay_inst
        (.clk, .reset_n, .load(dec.delay_we), .data(dec.arg[TRIG_DELAY_W-1:0]),
         .value(trig_delay));

    setting_reg #(.payload_t(fb_cap_t), .RESET_VAL(FB_CAP_DEFAULT)) fb_cap_inst
        (.clk, .reset_n, .load(dec.fbcap_we), .data(dec.arg[FB_CAP_W-1:0]), .value(fb_cap));

    setting_reg #(.payload_t(trig_mode_t), .RESET_VAL(TRIG_MODE_DEFAULT),
                  .ONEHOT_CHECK(1'b1)) trig_mode_inst
        (.clk, .reset_n, .load(dec.mode_we), .data(dec.mode), .value(trig_mode));

    channel_mask channel_mask_inst (.clk, .reset_n, .op(dec.mask_op), .chan(dec.mask_chan),
                                    .mask(chan_mask));

    onehot_select #(.WIDTH(NUM_PROBES)) probe_sel_inst
        (.clk, .reset_n, .we(dec.probe_we), .idx(dec.sel_idx), .sel(probe_sel));

    onehot_select #(.WIDTH(NUM_CHANNELS)) res_sel_inst
        (.clk, .reset_n, .we(dec.res_we), .idx(dec.sel_idx), .sel(res_sel));

    ////////////////////////////////////////
    // Pulses
    ////////////////////////////////////////
    pulse_gen #(.LENGTH(LEN_START_CONFIG)) start_config_inst
        (.clk, .reset_n, .fire(dec.fire[FIRE_START_CONFIG]), .active(start_config));

    pulse_gen #(.LENGTH(LEN_FORCE_TRIG)) force_trig_inst
        (.clk, .reset_n, .fire(dec.fire[FIRE_FORCE_TRIG]), .active(force_trig));

    pulse_gen #(.LENGTH(LEN_RESET_ASIC)) reset_asic_inst
        (.clk, .reset_n, .fire(dec.fire[FIRE_RESET_ASIC]), .active(reset_asic));

    assign reset_asic_b = ~reset_asic;                          // ASIC reset is active low

endmodule

/* hw/cmd_pkg.sv */
package cmd_pkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////
    localparam int NUM_FLAGS    = 6;
    localparam int NUM_PROBES   = 192;
    localparam int NUM_CHANNELS = 64;
    localparam int NUM_PULSES   = 3;
    localparam int ARG_W        = 12;
    localparam int CALI_DAC_W   = 12;
    localparam int TRIG_DELAY_W = 8;
    localparam int FB_CAP_W     = 4;
    localparam int MASK_CHAN_W  = 6;
    localparam int SEL_IDX_W    = 8;

    typedef logic [15:0]             ctrl_word_t;
    typedef logic [2:0]              flag_idx_t;    // Bit i of flags_t, start_acq is bit 0
    typedef logic [3:0]              trig_mode_t;   // Internal, external, self-OR, self-AND
    typedef logic [CALI_DAC_W-1:0]   cali_dac_t;
    typedef logic [TRIG_DELAY_W-1:0] trig_delay_t;
    typedef logic [FB_CAP_W-1:0]     fb_cap_t;
    typedef logic [NUM_CHANNELS-1:0] chan_mask_t;   // Channel n sits at bit 64 - n

    typedef struct packed {
        logic only_ex_trig;
        logic val_evt;
        logic hold;
        logic adc_test;
        logic trig_run;
        logic start_acq;
    } flags_t;

    typedef enum logic [2:0] {
        MASK_NONE,
        MASK_CLEAR_ALL,
        MASK_SET_ALL,
        MASK_SET_BIT,
        MASK_CLEAR_BIT
    } mask_op_t;

    typedef struct packed {
        logic                   flag_we;
        flag_idx_t              flag_idx;
        logic                   flag_val;
        logic                   cali_we;
        logic                   delay_we;
        logic                   fbcap_we;
        logic                   mode_we;
        trig_mode_t             mode;
        logic [ARG_W-1:0]       arg;
        mask_op_t               mask_op;
        logic [MASK_CHAN_W-1:0] mask_chan;
        logic                   probe_we;
        logic                   res_we;
        logic [SEL_IDX_W-1:0]   sel_idx;
        logic [NUM_PULSES-1:0]  fire;
    } decoded_cmd_t;

    ////////////////////////////////////////
    // Command codes
    ////////////////////////////////////////
    // Set codes in flag index order, the clear code has bit 0 low
    localparam ctrl_word_t FLAG_CODE [NUM_FLAGS] = '{16'hFFA1, 16'h00A1, 16'hF301,
                                                      16'hFFB1, 16'hF2F1, 16'hF5F1};
    localparam logic [3:0]  CMD_CALI_PREFIX     = 4'h5;
    localparam logic [7:0]  CMD_DELAY_PREFIX    = 8'hF4;
    localparam logic [11:0] CMD_FBCAP_PREFIX    = 12'hACA;
    localparam logic [7:0]  CMD_MODE_PREFIX     = 8'hAA;
    localparam ctrl_word_t  CMD_MASK_CLEAR      = 16'hFFDF;
    localparam ctrl_word_t  CMD_MASK_ALL        = 16'hFFDC;
    localparam logic [7:0]  CMD_MASK_SET_PREFIX = 8'hFC;
    localparam logic [7:0]  CMD_MASK_CLR_PREFIX = 8'hFB;
    localparam logic [7:0]  CMD_PROBE_PREFIX    = 8'h30;
    localparam logic [7:0]  CMD_RES_PREFIX      = 8'h34;
    localparam ctrl_word_t  CMD_START_CONFIG    = 16'h00B1;
    localparam ctrl_word_t  CMD_FORCE_TRIG      = 16'hFFE0;
    localparam ctrl_word_t  CMD_RESET_ASIC      = 16'hFFC0;

    // Fire bit positions
    localparam int FIRE_START_CONFIG = 0;
    localparam int FIRE_FORCE_TRIG   = 1;
    localparam int FIRE_RESET_ASIC   = 2;

    ////////////////////////////////////////
    // Defaults and pulse lengths
    ////////////////////////////////////////
    localparam flags_t FLAGS_DEFAULT = '{only_ex_trig: 1'b0, val_evt: 1'b1, hold: 1'b0,
                                         adc_test: 1'b0, trig_run: 1'b0, start_acq: 1'b1};
    localparam cali_dac_t   CALI_DAC_DEFAULT   = 12'h500;
    localparam trig_delay_t TRIG_DELAY_DEFAULT = 8'h70;
    localparam fb_cap_t     FB_CAP_DEFAULT     = 4'hF;
    localparam trig_mode_t  TRIG_MODE_DEFAULT  = 4'b0001;
    localparam chan_mask_t  CHAN_MASK_DEFAULT  = '0;

    localparam int LEN_START_CONFIG = 17;
    localparam int LEN_FORCE_TRIG   = 6;
    localparam int LEN_RESET_ASIC   = 255;

endpackage

/* hw/flag_bank.sv */
`timescale 1ns/100ps

module flag_bank
(
    input  logic               clk,
    input  logic               reset_n,
    input  logic               we,
    input  cmd_pkg::flag_idx_t idx,
    input  logic               val,
    output cmd_pkg::flags_t    flags
);
    import cmd_pkg::*;

    ////////////////////////////////////////
    // Mode flags
    ////////////////////////////////////////
    // Index counts from the last struct field, start_acq is bit 0
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
        begin
            flags <= FLAGS_DEFAULT;                             // val_evt and start_acq start high
        end
        else if (we && (idx < NUM_FLAGS))
        begin
            flags[idx] <= val;                                  // Single bit write
        end
    end

endmodule

/* hw/onehot_select.sv */
`timescale 1ns/100ps

module onehot_select
#(
    parameter int WIDTH = 64
)
(
    input  logic                          clk,
    input  logic                          reset_n,
    input  logic                          we,
    input  logic [cmd_pkg::SEL_IDX_W-1:0] idx,
    output logic [WIDTH-1:0]              sel
);

    logic idx_ok;

    assign idx_ok = (idx != '0) && (idx <= WIDTH);              // Index counts from 1

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            sel <= '0;
        else if (we)
        begin
            if (idx_ok)
                sel <= WIDTH'(1) << (idx - 1'b1);
            else
                sel <= '0;                                      // Zero or out of range deselects all
        end
    end

    a_sel_onehot0: assert property (@(posedge clk) disable iff (!reset_n) $onehot0(sel))
        else $error("onehot_select: more than one select active");

endmodule

/* hw/pulse_gen.sv */
`timescale 1ns/100ps

module pulse_gen
#(
    parameter int LENGTH = 16
)
(
    input  logic clk,
    input  logic reset_n,
    input  logic fire,
    output logic active
);

    localparam int CNT_W = $clog2(LENGTH + 1);

    logic [CNT_W-1:0] cnt;

    // Fire reloads the full length even mid pulse
    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            cnt <= '0;
        else if (fire)
            cnt <= CNT_W'(LENGTH);
        else if (cnt != '0)
            cnt <= cnt - 1'b1;
    end

    assign active = (cnt != '0);                                // High for LENGTH cycles

    a_cnt_bound: assert property (@(posedge clk) disable iff (!reset_n) cnt <= CNT_W'(LENGTH))
        else $error("pulse_gen: counter above LENGTH");

endmodule

/* hw/setting_reg.sv */
`timescale 1ns/100ps

module setting_reg
#(
    parameter type      payload_t    = logic [7:0],
    parameter payload_t RESET_VAL    = '0,
    parameter bit       ONEHOT_CHECK = 1'b0
)
(
    input  logic     clk,
    input  logic     reset_n,
    input  logic     load,
    input  payload_t data,
    output payload_t value
);

    always_ff @(posedge clk or negedge reset_n)
    begin
        if (!reset_n)
            value <= RESET_VAL;
        else if (load)
            value <= data;                                      // Hold otherwise
    end

    // One-hot settings must never be left empty or doubled by a write
    if (ONEHOT_CHECK)
    begin : g_onehot
        a_onehot: assert property (@(posedge clk) disable iff (!reset_n) $onehot(value))
            else $error("setting_reg: value lost its one-hot encoding");
    end

endmodule

/* run_sim.sh */
#!/bin/sh
# Builds the command interpreter testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cmd_interpreter -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_cmd_interpreter)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "Testbench passed"; then
    exit 0
fi
exit 1

/* verif/tb_model.svh */
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

////////////////////////////////////////
// Command table constants
////////////////////////////////////////
// Set codes, entry i drives flag bit i
localparam logic [15:0] FLAG_SET [6] = '{16'hFFA1, 16'h00A1, 16'hF301,
                                         16'hFFB1, 16'hF2F1, 16'hF5F1};
localparam logic [15:0] PULSE_CODE [3] = '{16'h00B1, 16'hFFE0, 16'hFFC0};
localparam int          PULSE_LEN [3]  = '{17, 6, 255};

logic [5:0]   exp_flags;       // only_ex_trig down to start_acq
logic [11:0]  exp_cali;
logic [7:0]   exp_delay;
logic [3:0]   exp_fbcap;
logic [3:0]   exp_mode;
logic [63:0]  exp_mask;
logic [191:0] exp_probe;
logic [63:0]  exp_res;
logic [31:0]  lcg_state = 32'h7fe4_6810;

// Low LCG bits repeat quickly, so only the upper ones are handed out
function automatic logic [31:0] rand32();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return {8'd0, lcg_state[31:8]};
endfunction

task automatic model_reset();
    exp_flags = 6'b010001;     // val_evt and start_acq
    exp_cali  = 12'h500;
    exp_delay = 8'h70;
    exp_fbcap = 4'hF;
    exp_mode  = 4'b0001;       // Internal trigger
    exp_mask  = '0;
    exp_probe = '0;
    exp_res   = '0;
endtask

////////////////////////////////////////
// Apply one word to the model
////////////////////////////////////////
task automatic apply_word(input logic [15:0] w);
    logic [7:0] nn;
    int         fi;
    nn = w[7:0];
    fi = -1;
    for (int i = 0; i < 6; i++)
        if (w[15:1] == FLAG_SET[i][15:1])
            fi = i;
    if (fi >= 0)
        exp_flags[fi] = w[0];
    else if (w[15:12] == 4'h5)
        exp_cali = w[11:0];
    else if (w[15:8] == 8'hF4)
        exp_delay = w[7:0];
    else if (w[15:4] == 12'hACA)
        exp_fbcap = w[3:0];
    else if (w[15:8] == 8'hAA && nn >= 1 && nn <= 4)
        exp_mode = 4'd1 << (nn - 1);
    else if (w == 16'hFFDF)
        exp_mask = '0;
    else if (w == 16'hFFDC)
        exp_mask = '1;
    else if (w[15:8] == 8'hFC && nn >= 1 && nn <= 64)
        exp_mask[64 - nn] = 1'b1;                 // Channel 1 is the MSB
    else if (w[15:8] == 8'hFB && nn >= 1 && nn <= 64)
        exp_mask[64 - nn] = 1'b0;
    else if (w[15:8] == 8'h30)
        exp_probe = (nn >= 1 && nn <= 192) ? (192'd1 << (nn - 1)) : '0;
    else if (w[15:8] == 8'h34)
        exp_res = (nn >= 1 && nn <= 64) ? (64'd1 << (nn - 1)) : '0;
endtask

`endif

/* verif/tb_cmd_interpreter.sv */
`timescale 1ns/100ps

module tb_cmd_interpreter;
    import cmd_pkg::*;

    localparam int TIMEOUT = 1000;

    logic          clk;
    logic          reset_n;
    logic          cmd_valid;
    ctrl_word_t    cmd_word;
    flags_t        flags;
    cali_dac_t     cali_dac;
    trig_delay_t   trig_delay;
    fb_cap_t       fb_cap;
    trig_mode_t    trig_mode;
    chan_mask_t    chan_mask;
    logic [191:0]  probe_sel;
    logic [63:0]   res_sel;
    logic          start_config;
    logic          force_trig;
    logic          reset_asic_b;
    string         test_name;
    int            tests = 0;
    int            checks = 0;
    int            errors = 0;
    int            check_mark;
    int            error_mark;

    `include "tb_model.svh"

    cmd_interpreter_top cmd_interpreter_top_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;                    // 8 ns period
    end

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////
    function automatic logic [15:0] table_word(input int kind);
        logic [31:0] r;
        r = rand32();
        case (kind)
            0: return {FLAG_SET[r % 6][15:1], r[8]};
            1: return {4'h5, r[19:8]};
            2: return {8'hF4, r[15:8]};
            3: return {12'hACA, r[11:8]};
            4: return {8'hAA, 5'd0, r[10:8]};     // Codes 0 and 5 to 7 are invalid
            5: return r[9] ? 16'hFFDF : 16'hFFDC;
            6: return {(r[9] ? 8'hFC : 8'hFB), 8'(r[23:10] % 71)};
            7: return {8'h30, r[15:8]};
            8: return {8'h34, 8'(r[23:10] % 80)};
            default: return r[15:0];
        endcase
    endfunction

    // Words next to real codes that must match nothing
    function automatic logic [15:0] unmatched_word();
        logic [31:0] r;
        r = rand32();
        case (r[1:0])
            0: return {8'hAA, (r[9:2] >= 1 && r[9:2] <= 4) ? 8'h00 : r[9:2]};
            1: return {8'hFC, 8'(65 + r[15:2] % 191)};
            2: return {8'hFB, r[20] ? 8'h00 : 8'(65 + r[15:2] % 191)};
            default: return {4'hE, r[13:2]};
        endcase
    endfunction

    function automatic logic pulse_active(input int idx);
        case (idx)
            0: return start_config;
            1: return force_trig;
            default: return !reset_asic_b;
        endcase
    endfunction

    task automatic fail_timeout(input string what);
        $display("Timeout while waiting for %s", what);
        $display("Testbench failed");
        $finish;
    endtask

    task automatic check_field(input string what, input logic [191:0] exp,
                               input logic [191:0] act);
        checks++;
        assert (exp === act)
        else
        begin
            $display("Fail %s %s expected %0h actual %0h", test_name, what, exp, act);
            errors++;
        end
    endtask

    task automatic check_outputs();
        check_field("flags", 192'(exp_flags), 192'(flags));
        check_field("cali_dac", 192'(exp_cali), 192'(cali_dac));
        check_field("trig_delay", 192'(exp_delay), 192'(trig_delay));
        check_field("fb_cap", 192'(exp_fbcap), 192'(fb_cap));
        check_field("trig_mode", 192'(exp_mode), 192'(trig_mode));
        check_field("chan_mask", 192'(exp_mask), 192'(chan_mask));
        check_field("probe_sel", exp_probe, probe_sel);
        check_field("res_sel", 192'(exp_res), 192'(res_sel));
    endtask

    task automatic send_word(input logic [15:0] w);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_word  <= w;
        @(posedge clk);                           // Decoder samples here
        cmd_valid <= 1'b0;
        apply_word(w);
    endtask

    task automatic send_burst(input int n);
        logic [15:0] w;
        for (int i = 0; i < n; i++)
        begin
            w = table_word(rand32() % 10);
            @(posedge clk);
            cmd_valid <= 1'b1;
            cmd_word  <= w;
            apply_word(w);
        end
        @(posedge clk);
        cmd_valid <= 1'b0;
    endtask

    // Settings land one edge after the sampling edge
    task automatic settle_and_check();
        @(posedge clk);
        @(negedge clk);
        check_outputs();
    endtask

    task automatic wait_pulses_idle();
        int guard;
        guard = 0;
        while ((start_config || force_trig || !reset_asic_b) && guard < TIMEOUT)
        begin
            @(negedge clk);
            guard++;
        end
        if (guard >= TIMEOUT)
            fail_timeout("pulses to go idle");
    endtask

    ////////////////////////////////////////
    // Pulse width measurement
    ////////////////////////////////////////
    task automatic pulse_width(input int idx, input int refire_at);
        int cycles;
        int width;
        int expected;
        expected = PULSE_LEN[idx] + ((refire_at == 0) ? 0 : refire_at + 2);
        @(posedge clk);
        cmd_valid <= 1'b1;
        cmd_word  <= PULSE_CODE[idx];
        @(posedge clk);
        cmd_valid <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!pulse_active(idx) && cycles < TIMEOUT)
        begin
            @(negedge clk);
            cycles++;
        end
        if (cycles >= TIMEOUT)
            fail_timeout("pulse start");
        check_field($sformatf("pulse %0d start", idx), 192'd2, 192'(cycles));
        width = 0;
        while (pulse_active(idx) && width < TIMEOUT)
        begin
            width++;
            @(posedge clk);
            cmd_valid <= (width == refire_at);     // Re-fire mid pulse
            cmd_word  <= PULSE_CODE[idx];
            @(negedge clk);
        end
        if (width >= TIMEOUT)
            fail_timeout("pulse end");
        check_field($sformatf("pulse %0d width", idx), 192'(expected), 192'(width));
    endtask

    task automatic start_test(input string name);
        test_name  = name;
        check_mark = checks;
        error_mark = errors;
    endtask

    task automatic end_test();
        tests++;
        $display("%s: %0d checks, %0d errors", test_name, checks - check_mark,
                 errors - error_mark);
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////
    initial
    begin
        reset_n   = 1'b0;
        cmd_valid = 1'b0;
        cmd_word  = '0;
        model_reset();
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;

        start_test("reset_defaults");
        @(negedge clk);
        check_outputs();
        check_field("start_config", 192'd0, 192'(start_config));
        check_field("force_trig", 192'd0, 192'(force_trig));
        check_field("reset_asic_b", 192'd1, 192'(reset_asic_b));
        end_test();

        start_test("flags_values");
        repeat (80)
        begin
            send_word(table_word(rand32() % 5));
            settle_and_check();
        end
        end_test();

        start_test("channel_mask");
        repeat (80)
        begin
            send_word(table_word((rand32() % 4 == 0) ? 5 : 6));
            settle_and_check();
        end
        end_test();

        start_test("onehot_selects");
        repeat (50)
        begin
            send_word(table_word(7 + rand32() % 2));
            settle_and_check();
        end
        end_test();

        start_test("pulse_widths");
        for (int p = 0; p < 3; p++)
        begin
            wait_pulses_idle();
            pulse_width(p, 0);
            wait_pulses_idle();
            pulse_width(p, 3);
        end
        end_test();

        start_test("back_to_back");
        repeat (12)
        begin
            send_burst(8);
            settle_and_check();
        end
        end_test();

        start_test("unmatched_words");
        repeat (30)
        begin
            send_word(unmatched_word());
            settle_and_check();
        end
        end_test();

        $display("Tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("Testbench passed");
        else
            $display("Testbench failed");
        $finish;
    end

endmodule
